// ==== intr_mem_sys.f ====
logic/intr_types_pkg.sv
logic/mem_map_pkg.sv
logic/wr_req_port.sv
logic/intr_wr_fifo.sv
logic/mem_bank.sv
logic/rd_port.sv
logic/intr_mem_sys.sv
test/intr_mem_sys_assertions.sv
test/intr_mem_sys_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f intr_mem_sys.f \
		--top-module intr_mem_sys_tb
	./obj_dir/Vintr_mem_sys_tb | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif grep -qx "Finished with no errors" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation ended early"; exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing --assert -f intr_mem_sys.f \
		--top-module intr_mem_sys_tb

clean:
	rm -rf obj_dir $(LOG)

// ==== test/intr_mem_sys_tb.sv ====
`default_nettype none

module intr_mem_sys_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          max_outstanding = 8;
    localparam int          ocm_depth       = 256;
    localparam int          ddr_depth       = 1024;
    localparam int          wait_limit      = 300;
    localparam logic [31:0] ocm_top         = 32'h0003_ffff;
    localparam logic [31:0] ddr_bottom      = 32'h0010_0000;
    localparam logic [31:0] ddr_top         = 32'h3fff_ffff;

    logic                    sw_clk;
    logic                    rstn;
    logic                    wr_req;
    logic                    wr_ack;
    intr_types_pkg::wr_req_t wr_info;
    logic                    rd_req;
    logic                    rd_ack;
    logic [31:0]             rd_addr;
    logic [63:0]             rd_data;

    logic [31:0] rng_state = 32'hb18f_c791;
    logic [63:0] ocm_model [int];
    logic [63:0] ddr_model [int];
    int          errors    = 0;
    int          timeouts  = 0;
    bit          timed_out = 1'b0;

    intr_mem_sys #(
        .max_outstanding(max_outstanding),
        .ocm_depth(ocm_depth),
        .ddr_depth(ddr_depth),
        .ocm_ack_delay(1),
        .ddr_ack_delay(4)
    ) DUT (
        .sw_clk, .rstn, .wr_req, .wr_ack, .wr_info, .rd_req, .rd_ack, .rd_addr, .rd_data
    );

    bind intr_wr_fifo intr_mem_sys_assertions u_handshake_checks (
        .sw_clk(sw_clk), .rstn(rstn), .push(push), .full(full),
        .ocm_valid(ocm_valid), .ddr_valid(ddr_valid), .ocm_done(ocm_done),
        .ddr_done(ddr_done), .mem_info(mem_info)
    );

    initial begin
        sw_clk = 1'b0;
        forever #5 sw_clk = ~sw_clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [63:0] random_word();
        return {next_random(), next_random()};
    endfunction

    // Kind 0 is OCM, 1 is DDR, anything else unmapped. Upper bits vary so indices alias.
    function automatic logic [31:0] random_addr(input int kind);
        logic [31:0] r;
        logic [31:0] slot;
        r    = next_random();
        slot = (next_random() % 32'd16) << 3;
        case (kind)
            0:       return (r & 32'h0003_f000) | slot;
            1:       return (ddr_bottom + (r & 32'h3fe0_2000)) | slot;
            default: return (32'h0008_0000 + (r & 32'h0007_0000)) | slot;
        endcase
    endfunction

    // Low lanes of the new data replace the old word, at most eight of them.
    function automatic logic [63:0] merge_lanes(input logic [63:0] old_word,
                                                input logic [63:0] data,
                                                input logic [3:0]  bytes);
        logic [63:0] word;
        word = old_word;
        for (int i = 0; i < 8; i++) begin
            if (i < int'(bytes)) begin
                word[8*i +: 8] = data[8*i +: 8];
            end
        end
        return word;
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [63:0] data,
                                        input logic [3:0] bytes);
        int idx;
        if (addr <= ocm_top) begin
            idx = int'((addr >> 3) % 32'(ocm_depth));
            ocm_model[idx] = merge_lanes(ocm_model.exists(idx) ? ocm_model[idx] : '0,
                                         data, bytes);
        end else if (addr >= ddr_bottom && addr <= ddr_top) begin
            idx = int'((addr >> 3) % 32'(ddr_depth));
            ddr_model[idx] = merge_lanes(ddr_model.exists(idx) ? ddr_model[idx] : '0,
                                         data, bytes);
        end
    endfunction

    function automatic logic [63:0] model_read(input logic [31:0] addr);
        logic [63:0] word;
        int          idx;
        word = '0;
        if (addr <= ocm_top) begin
            idx = int'((addr >> 3) % 32'(ocm_depth));
            if (ocm_model.exists(idx)) word = ocm_model[idx];
        end else if (addr >= ddr_bottom && addr <= ddr_top) begin
            idx = int'((addr >> 3) % 32'(ddr_depth));
            if (ddr_model.exists(idx)) word = ddr_model[idx];
        end
        return word;
    endfunction

    task automatic wait_ack(input bit on_read, input logic level, output int cycles);
        logic seen;
        cycles = 0;
        seen   = on_read ? rd_ack : wr_ack;
        while (seen !== level && cycles < wait_limit) begin
            @(negedge sw_clk);
            cycles++;
            seen = on_read ? rd_ack : wr_ack;
        end
        if (seen !== level) begin
            timeouts++;
            timed_out = 1'b1;
            $display("Timeout: %s did not reach %0b within %0d cycles",
                     on_read ? "rd_ack" : "wr_ack", level, wait_limit);
        end
    endtask

    task automatic do_write(input logic [31:0] addr, input logic [63:0] data,
                            input logic [3:0] bytes, output int ack_cycles);
        int cycles;
        ack_cycles = 0;
        if (timed_out) return;
        @(negedge sw_clk);
        wr_info.addr  = addr;
        wr_info.data  = data;
        wr_info.bytes = bytes;
        wr_info.qos   = 4'(next_random());
        wr_req        = 1'b1;
        wait_ack(1'b0, 1'b1, ack_cycles);
        if (timed_out) return;
        wr_req = 1'b0;
        model_write(addr, data, bytes);
        wait_ack(1'b0, 1'b0, cycles);
    endtask

    task automatic do_read(input logic [31:0] addr);
        logic [63:0] expected;
        int          cycles;
        if (timed_out) return;
        @(negedge sw_clk);
        rd_addr = addr;
        rd_req  = 1'b1;
        wait_ack(1'b1, 1'b1, cycles);
        if (timed_out) return;
        expected = model_read(addr);
        assert (rd_data === expected) else begin
            errors++;
            $display("[ERROR] rd_data at addr %h: got %h, expected %h", addr, rd_data, expected);
        end
        rd_req = 1'b0;
        wait_ack(1'b1, 1'b0, cycles);
    endtask

    initial begin
        logic [31:0] addr;
        int          cycles;
        int          longest;
        int          failed_assertions;
        logic [31:0] touched [$];
        rstn    = 1'b0;
        wr_req  = 1'b0;
        wr_info = '0;
        rd_req  = 1'b0;
        rd_addr = '0;
        repeat (10) @(posedge sw_clk);
        @(negedge sw_clk);
        rstn = 1'b1;

        // Idle handshakes and zeroed banks.
        assert (wr_ack === 1'b0) else begin
            errors++;
            $display("[ERROR] wr_ack after reset: got %h, expected %h", wr_ack, 1'b0);
        end
        assert (rd_ack === 1'b0) else begin
            errors++;
            $display("[ERROR] rd_ack after reset: got %h, expected %h", rd_ack, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            do_read(random_addr(i % 2));
        end

        // Full words, then partial byte counts over a known word.
        for (int i = 0; i < 8; i++) begin
            addr = random_addr(i % 2);
            do_write(addr, random_word(), 4'd8, cycles);
            do_read(addr);
        end
        for (int i = 0; i < 24; i++) begin
            addr = random_addr(i % 2);
            do_write(addr, random_word(), 4'd8, cycles);
            do_write(addr, random_word(), 4'(next_random() % 32'd9), cycles);
            do_read(addr);
        end

        // Back-to-back DDR writes on a few words overrun the queue.
        longest = 0;
        for (int i = 0; i < 3 * max_outstanding; i++) begin
            addr = ddr_bottom + ((next_random() % 32'd4) << 3);
            touched.push_back(addr);
            do_write(addr, random_word(), 4'd8, cycles);
            if (cycles > longest) begin
                longest = cycles;
            end
        end
        assert (timed_out || longest > 1) else begin
            errors++;
            $display("No back-pressure was seen on wr_ack during the write burst");
        end
        foreach (touched[i]) begin
            do_read(touched[i]);
        end

        // Unmapped writes leave the aliased OCM and DDR words alone.
        for (int i = 0; i < 8; i++) begin
            addr = random_addr(2);
            do_write(addr, random_word(), 4'd8, cycles);
            do_read(addr);
            do_read(addr & 32'h0003_ffff);
            do_read(ddr_bottom | (addr & 32'h0000_1fff));
        end

        for (int i = 0; i < 400; i++) begin
            addr = random_addr(int'(next_random() % 32'd3));
            if (next_random() % 32'd2 == 0) begin
                do_write(addr, random_word(), 4'(next_random()), cycles);
            end else begin
                do_read(addr);
            end
        end

        failed_assertions = DUT.u_wr_fifo.u_handshake_checks.failures;
        $display("Checks done: %0d errors, %0d assertion failures, %0d timeouts",
                 errors, failed_assertions, timeouts);
        if (errors == 0 && failed_assertions == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/intr_mem_sys_assertions.sv ====
`default_nettype none

module intr_mem_sys_assertions (
    input  wire logic                sw_clk,
    input  wire logic                rstn,
    input  wire logic                push,
    input  wire logic                full,
    input  wire logic                ocm_valid,
    input  wire logic                ddr_valid,
    input  wire logic                ocm_done,
    input  wire logic                ddr_done,
    input  intr_types_pkg::wr_req_t  mem_info
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;

    // Only one bank is addressed at a time.
    one_bank_valid: assert property (@(posedge sw_clk) disable iff (!rstn)
        !(ocm_valid && ddr_valid))
        else begin
            $error("ocm_valid and ddr_valid are high together");
            failures++;
        end

    ocm_valid_held: assert property (@(posedge sw_clk) disable iff (!rstn)
        ocm_valid && !ocm_done |=> ocm_valid)
        else begin
            $error("ocm_valid dropped before ocm_done");
            failures++;
        end

    ddr_valid_held: assert property (@(posedge sw_clk) disable iff (!rstn)
        ddr_valid && !ddr_done |=> ddr_valid)
        else begin
            $error("ddr_valid dropped before ddr_done");
            failures++;
        end

    // Valid falls in the cycle after done.
    valid_drops: assert property (@(posedge sw_clk) disable iff (!rstn)
        ocm_done || ddr_done |=> !(ocm_valid || ddr_valid))
        else begin
            $error("valid still high after done");
            failures++;
        end

    info_stable: assert property (@(posedge sw_clk) disable iff (!rstn)
        (ocm_valid || ddr_valid) && !(ocm_done || ddr_done) |=> $stable(mem_info))
        else begin
            $error("mem_info changed while valid was high");
            failures++;
        end

    no_push_when_full: assert property (@(posedge sw_clk) disable iff (!rstn)
        push |-> !full)
        else begin
            $error("push while the queue is full");
            failures++;
        end

endmodule

`default_nettype wire

// ==== logic/intr_mem_sys.sv ====
`default_nettype none

module intr_mem_sys #(
    parameter int max_outstanding = 8,
    parameter int ocm_depth       = 256,
    parameter int ddr_depth       = 1024,
    parameter int ocm_ack_delay   = 1,
    parameter int ddr_ack_delay   = 4
) (
    input  wire logic                                   sw_clk,
    input  wire logic                                   rstn,
    input  wire logic                                   wr_req,
    output logic                                        wr_ack,
    input  intr_types_pkg::wr_req_t                     wr_info,
    input  wire logic                                   rd_req,
    output logic                                        rd_ack,
    input  wire logic [intr_types_pkg::addr_width-1:0]  rd_addr,
    output logic [intr_types_pkg::data_width-1:0]       rd_data
);

    logic                                  push;
    intr_types_pkg::wr_req_t               push_info;
    logic                                  full;
    logic                                  wr_pending;
    intr_types_pkg::wr_req_t               mem_info;
    logic                                  ocm_valid;
    logic                                  ddr_valid;
    logic                                  ocm_done;
    logic                                  ddr_done;
    logic [$clog2(ocm_depth)-1:0]          ocm_index;
    logic [$clog2(ddr_depth)-1:0]          ddr_index;
    logic [intr_types_pkg::data_width-1:0] ocm_word;
    logic [intr_types_pkg::data_width-1:0] ddr_word;

    wr_req_port u_wr_port (
        .sw_clk, .rstn, .wr_req, .wr_ack, .wr_info, .full, .push, .push_info
    );

    intr_wr_fifo #(.max_outstanding(max_outstanding)) u_wr_fifo (
        .sw_clk, .rstn, .push, .push_info, .full, .wr_pending, .mem_info,
        .ocm_valid, .ddr_valid, .ocm_done, .ddr_done
    );

    mem_bank #(.depth(ocm_depth), .ack_delay(ocm_ack_delay)) ocm_bank (
        .sw_clk, .rstn, .wr_valid(ocm_valid), .wr_info(mem_info),
        .wr_done(ocm_done), .rd_index(ocm_index), .rd_word(ocm_word)
    );

    mem_bank #(.depth(ddr_depth), .ack_delay(ddr_ack_delay)) ddr_bank (
        .sw_clk, .rstn, .wr_valid(ddr_valid), .wr_info(mem_info),
        .wr_done(ddr_done), .rd_index(ddr_index), .rd_word(ddr_word)
    );

    rd_port #(.ocm_depth(ocm_depth), .ddr_depth(ddr_depth)) u_rd_port (
        .sw_clk, .rstn, .rd_req, .rd_ack, .rd_addr, .rd_data, .wr_pending,
        .ocm_index, .ocm_word, .ddr_index, .ddr_word
    );

endmodule

`default_nettype wire

// ==== logic/rd_port.sv ====
`default_nettype none

module rd_port #(
    parameter int ocm_depth = 256,
    parameter int ddr_depth = 1024
) (
    input  wire logic                                   sw_clk,
    input  wire logic                                   rstn,
    input  wire logic                                   rd_req,
    output logic                                        rd_ack,
    input  wire logic [intr_types_pkg::addr_width-1:0]  rd_addr,
    output logic [intr_types_pkg::data_width-1:0]       rd_data,
    input  wire logic                                   wr_pending,
    output logic [$clog2(ocm_depth)-1:0]                ocm_index,
    input  wire logic [intr_types_pkg::data_width-1:0]  ocm_word,
    output logic [$clog2(ddr_depth)-1:0]                ddr_index,
    input  wire logic [intr_types_pkg::data_width-1:0]  ddr_word
);

    localparam int word_lsb = $clog2(intr_types_pkg::data_width / 8);

    typedef enum logic {
        rd_idle,
        rd_done
    } rd_state_t;

    rd_state_t state;
    logic      start;

    assign ocm_index = rd_addr[word_lsb +: $clog2(ocm_depth)];
    assign ddr_index = rd_addr[word_lsb +: $clog2(ddr_depth)];
    assign rd_ack    = (state == rd_done);

    // A read sees every earlier write, so it waits for the queue to drain.
    assign start = (state == rd_idle) && rd_req && !wr_pending;

    always_ff @(posedge sw_clk) begin
        if (!rstn) begin
            state <= rd_idle;
        end else if (start) begin
            state <= rd_done;
        end else if (state == rd_done && !rd_req) begin
            state <= rd_idle;
        end
    end

    always_ff @(posedge sw_clk) begin
        if (start) begin
            case (mem_map_pkg::decode_address(rd_addr))
                mem_map_pkg::ocm_mem: rd_data <= ocm_word;
                mem_map_pkg::ddr_mem: rd_data <= ddr_word;
                default:              rd_data <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_bank.sv ====
`default_nettype none

module mem_bank #(
    parameter int depth     = 256,
    parameter int ack_delay = 1
) (
    input  wire logic                               sw_clk,
    input  wire logic                               rstn,
    input  wire logic                               wr_valid,
    input  intr_types_pkg::wr_req_t                 wr_info,
    output logic                                    wr_done,
    input  wire logic [$clog2(depth)-1:0]           rd_index,
    output logic [intr_types_pkg::data_width-1:0]   rd_word
);

    localparam int index_width = $clog2(depth);
    localparam int lanes       = intr_types_pkg::data_width / 8;
    localparam int word_lsb    = $clog2(lanes);
    localparam int cnt_width   = $clog2(ack_delay + 1);

    logic [intr_types_pkg::data_width-1:0] mem [depth];
    logic [cnt_width-1:0]                  count;
    logic [index_width-1:0]                wr_index;
    logic                                  wr_fire;

    // Word index wraps modulo the bank depth.
    assign wr_index = wr_info.addr[word_lsb +: index_width];

    // Count edges of a valid that has not been acknowledged yet.
    assign wr_fire = wr_valid && !wr_done && (count == cnt_width'(ack_delay - 1));

    assign rd_word = mem[rd_index];

    always_ff @(posedge sw_clk) begin
        if (!rstn) begin
            count   <= '0;
            wr_done <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            if (wr_fire) begin
                count   <= '0;
                wr_done <= 1'b1;
            end else if (wr_valid && !wr_done) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge sw_clk) begin
        if (!rstn) begin
            for (int w = 0; w < depth; w++) begin
                mem[w] <= '0;
            end
        end else if (wr_fire) begin
            // Only the low byte lanes named by the count are written.
            for (int i = 0; i < lanes; i++) begin
                if (i < int'(wr_info.bytes)) begin
                    mem[wr_index][8*i +: 8] <= wr_info.data[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/intr_wr_fifo.sv ====
`default_nettype none

module intr_wr_fifo #(
    parameter int max_outstanding = 8
) (
    input  wire logic                    sw_clk,
    input  wire logic                    rstn,
    input  wire logic                    push,
    input  intr_types_pkg::wr_req_t      push_info,
    output logic                         full,
    output logic                         wr_pending,
    output intr_types_pkg::wr_req_t      mem_info,
    output logic                         ocm_valid,
    output logic                         ddr_valid,
    input  wire logic                    ocm_done,
    input  wire logic                    ddr_done
);

    // One extra wrap bit separates full from empty.
    localparam int ptr_width = $clog2(max_outstanding) + 1;

    intr_types_pkg::wr_req_t   store [max_outstanding];
    logic [ptr_width-1:0]      wr_ptr;
    logic [ptr_width-1:0]      rd_ptr;
    logic                      empty;
    intr_types_pkg::wr_req_t   head;
    intr_types_pkg::wr_state_t state;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ptr_width-1] != rd_ptr[ptr_width-1]) &&
                   (wr_ptr[ptr_width-2:0] == rd_ptr[ptr_width-2:0]);
    assign head  = store[rd_ptr[ptr_width-2:0]];

    // Reads must wait for queued entries and for the write in flight.
    assign wr_pending = !empty || (state == intr_types_pkg::wait_ack);

    always_ff @(posedge sw_clk) begin
        if (push && !full) begin
            store[wr_ptr[ptr_width-2:0]] <= push_info;
        end
    end

    always_ff @(posedge sw_clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
        end else if (push && !full) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Dispatch state machine.
    always_ff @(posedge sw_clk) begin
        if (!rstn) begin
            rd_ptr    <= '0;
            ocm_valid <= 1'b0;
            ddr_valid <= 1'b0;
            state     <= intr_types_pkg::send_data;
        end else begin
            case (state)
                intr_types_pkg::send_data: begin
                    if (!empty) begin
                        rd_ptr <= rd_ptr + 1'b1;
                        case (mem_map_pkg::decode_address(head.addr))
                            mem_map_pkg::ocm_mem: begin
                                ocm_valid <= 1'b1;
                                state     <= intr_types_pkg::wait_ack;
                            end
                            mem_map_pkg::ddr_mem: begin
                                ddr_valid <= 1'b1;
                                state     <= intr_types_pkg::wait_ack;
                            end
                            // Unmapped writes are dropped here.
                            default: state <= intr_types_pkg::send_data;
                        endcase
                    end
                end
                intr_types_pkg::wait_ack: begin
                    if (ocm_done || ddr_done) begin
                        ocm_valid <= 1'b0;
                        ddr_valid <= 1'b0;
                        state     <= intr_types_pkg::send_data;
                    end
                end
                default: state <= intr_types_pkg::send_data;
            endcase
        end
    end

    // Held from pop until the next pop, so it is stable under valid.
    always_ff @(posedge sw_clk) begin
        if (state == intr_types_pkg::send_data && !empty) begin
            mem_info <= head;
        end
    end

endmodule

`default_nettype wire

// ==== logic/wr_req_port.sv ====
`default_nettype none

module wr_req_port (
    input  wire logic                    sw_clk,
    input  wire logic                    rstn,
    input  wire logic                    wr_req,
    output logic                         wr_ack,
    input  intr_types_pkg::wr_req_t      wr_info,
    input  wire logic                    full,
    output logic                         push,
    output intr_types_pkg::wr_req_t      push_info
);

    typedef enum logic {
        port_idle,
        port_ack
    } port_state_t;

    port_state_t state;

    // Ack follows the state, so it is high from capture until req falls.
    assign wr_ack = (state == port_ack);

    always_ff @(posedge sw_clk) begin
        if (!rstn) begin
            state <= port_idle;
            push  <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                port_idle: begin
                    // Hold off the ack while the queue has no room.
                    if (wr_req && !full) begin
                        push  <= 1'b1;
                        state <= port_ack;
                    end
                end
                port_ack: begin
                    if (!wr_req) begin
                        state <= port_idle;
                    end
                end
                default: state <= port_idle;
            endcase
        end
    end

    always_ff @(posedge sw_clk) begin
        if (state == port_idle && wr_req && !full) begin
            push_info <= wr_info;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_map_pkg.sv ====
`default_nettype none

package mem_map_pkg;

    typedef enum logic [1:0] {
        ocm_mem,
        ddr_mem,
        invalid_mem
    } mem_region_t;

    // On-chip RAM window.
    localparam logic [intr_types_pkg::addr_width-1:0] ocm_base  = 32'h0000_0000;
    localparam logic [intr_types_pkg::addr_width-1:0] ocm_limit = 32'h0003_ffff;

    // DDR window.
    localparam logic [intr_types_pkg::addr_width-1:0] ddr_base  = 32'h0010_0000;
    localparam logic [intr_types_pkg::addr_width-1:0] ddr_limit = 32'h3fff_ffff;

    // An address below base wraps to a large offset and fails the compare.
    function automatic mem_region_t decode_address(
        input logic [intr_types_pkg::addr_width-1:0] addr
    );
        mem_region_t region;
        region = invalid_mem;
        if ((addr - ocm_base) <= (ocm_limit - ocm_base)) begin
            region = ocm_mem;
        end else if ((addr - ddr_base) <= (ddr_limit - ddr_base)) begin
            region = ddr_mem;
        end
        return region;
    endfunction

endpackage

`default_nettype wire

// ==== logic/intr_types_pkg.sv ====
`default_nettype none

package intr_types_pkg;

    // Byte address of the interconnect.
    localparam int addr_width = 32;

    // One word of write or read data.
    localparam int data_width = 64;

    // Byte count of a write, 1 to 8.
    localparam int bytes_width = 4;

    // QoS tag carried with each write.
    localparam int qos_width = 4;

    // Write request as it moves from the port through the queue to a bank.
    typedef struct packed {
        logic [addr_width-1:0]  addr;
        logic [data_width-1:0]  data;
        logic [bytes_width-1:0] bytes;
        logic [qos_width-1:0]   qos;
    } wr_req_t;

    // Dispatch states of the outstanding-write queue.
    typedef enum logic {
        send_data,
        wait_ack
    } wr_state_t;

endpackage

`default_nettype wire
